//--- build.f
common/frontend_pkg.sv
common/fetch_mem_if.sv
common/predict_if.sv
predictor/return_stack.sv
predictor/branch_predictor.sv
src/fetch_stage.sv
src/fetch_buffer.sv
src/frontend_top.sv
testbench/tb_clock.sv
testbench/frontend_tb.sv

//--- common/fetch_mem_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fetch_mem_if;
  import frontend_pkg::*;

  logic            valid;
  logic            fence;
  logic [xlen-1:0] addr;
  logic            ready;
  // upper half is only meaningful for a 32-bit instruction.
  logic [xlen-1:0] rdata;

  modport fetch (output valid, output fence, output addr, input ready, input rdata);

  modport buffer (input valid, input fence, input addr, output ready, output rdata);

endinterface

`default_nettype wire

//--- common/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

  // ----------------------------------------------------------------------
  // widths and sizes
  // ----------------------------------------------------------------------

  localparam int xlen = 32;

  localparam int btb_depth = 16;
  localparam int btb_idx_w = $clog2(btb_depth);
  // the index starts at pc bit 1, so the tag holds everything above it.
  localparam int btb_tag_w = xlen - btb_idx_w - 1;

  localparam int ras_depth = 4;
  localparam int ras_ptr_w = $clog2(ras_depth);

  localparam int mem_credits = 2;
  localparam int credit_w = $clog2(mem_credits + 1);

  localparam int buf_depth = 8;
  localparam int buf_cnt_w = $clog2(buf_depth + 1);

  // ----------------------------------------------------------------------
  // reset values
  // ----------------------------------------------------------------------

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0100;

  // compressed nop, shown whenever no instruction is valid.
  localparam logic [xlen-1:0] nop_instr = 32'h0000_0001;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------

  typedef enum logic [1:0] {
    none      = 2'd0,
    branch    = 2'd1,
    jump_call = 2'd2,
    ret       = 2'd3
  } cf_kind_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    logic            taken;
    logic            valid;
  } fetch_rec_t;

endpackage

`default_nettype wire

//--- common/predict_if.sv
`timescale 1ns/1ns
`default_nettype none

interface predict_if;
  import frontend_pkg::*;

  logic [xlen-1:0] get_pc;
  logic            stall;

  logic            upd_valid;
  logic [xlen-1:0] upd_pc;
  cf_kind_t        upd_kind;
  logic            upd_taken;
  logic [xlen-1:0] upd_target;

  logic            pred_hit;
  cf_kind_t        pred_kind;
  logic            pred_taken;
  logic [xlen-1:0] pred_target;

  modport fetch (
    output get_pc, stall, upd_valid, upd_pc, upd_kind, upd_taken, upd_target,
    input  pred_hit, pred_kind, pred_taken, pred_target
  );

  modport predictor (
    input  get_pc, stall, upd_valid, upd_pc, upd_kind, upd_taken, upd_target,
    output pred_hit, pred_kind, pred_taken, pred_target
  );

endinterface

`default_nettype wire

//--- predictor/branch_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module branch_predictor (
  input wire logic     clk,
  input wire logic     rst,
  predict_if.predictor bp
);
  import frontend_pkg::*;

  logic [btb_depth-1:0] valid_q;
  logic [btb_tag_w-1:0] tag_mem    [btb_depth];
  cf_kind_t             kind_mem   [btb_depth];
  logic [xlen-1:0]      target_mem [btb_depth];
  logic [1:0]           cnt_mem    [btb_depth];

  logic [btb_idx_w-1:0] get_idx;
  logic [btb_idx_w-1:0] upd_idx;
  logic [btb_tag_w-1:0] upd_tag;
  logic                 hit;
  logic                 upd_hit;
  cf_kind_t             hit_kind;
  logic [1:0]           cnt_now;
  logic [1:0]           cnt_next;
  logic                 ras_push;
  logic                 ras_pop;
  logic [xlen-1:0]      ras_top;

  // ----------------------------------------------------------------------
  // lookup
  // ----------------------------------------------------------------------

  assign get_idx  = bp.get_pc[btb_idx_w:1];
  assign hit      = valid_q[get_idx] && (tag_mem[get_idx] == bp.get_pc[xlen-1:btb_idx_w+1]);
  assign hit_kind = hit ? kind_mem[get_idx] : none;

  assign bp.pred_hit    = hit;
  assign bp.pred_kind   = hit_kind;
  assign bp.pred_target = (hit_kind == ret) ? ras_top : target_mem[get_idx];

  always_comb begin
    case (hit_kind)
      branch:         bp.pred_taken = cnt_mem[get_idx][1];
      jump_call, ret: bp.pred_taken = 1'b1;
      default:        bp.pred_taken = 1'b0;
    endcase
  end

  // stack traffic only for a fetch that really advances.
  assign ras_push = (hit_kind == jump_call) && !bp.stall;
  assign ras_pop  = (hit_kind == ret) && !bp.stall;

  return_stack i_ras (
    .clk       (clk),
    .rst       (rst),
    .push      (ras_push),
    .pop       (ras_pop),
    .push_addr (bp.get_pc + xlen'(4)),
    .top_addr  (ras_top)
  );

  // ----------------------------------------------------------------------
  // update at resolution
  // ----------------------------------------------------------------------

  assign upd_idx = bp.upd_pc[btb_idx_w:1];
  assign upd_tag = bp.upd_pc[xlen-1:btb_idx_w+1];
  assign upd_hit = valid_q[upd_idx] && (tag_mem[upd_idx] == upd_tag);

  always_comb begin
    cnt_now = cnt_mem[upd_idx];
    if (bp.upd_taken) begin
      cnt_next = (cnt_now == 2'b11) ? cnt_now : cnt_now + 2'b01;
    end else begin
      cnt_next = (cnt_now == 2'b00) ? cnt_now : cnt_now - 2'b01;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      valid_q <= '0;
    end else if (bp.upd_valid && bp.upd_taken) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // a fresh entry starts weakly taken.
  always_ff @(posedge clk) begin
    if (bp.upd_valid) begin
      if (upd_hit) begin
        cnt_mem[upd_idx] <= cnt_next;
      end else if (bp.upd_taken) begin
        cnt_mem[upd_idx] <= 2'b10;
      end
      if (bp.upd_taken) begin
        tag_mem[upd_idx]    <= upd_tag;
        kind_mem[upd_idx]   <= bp.upd_kind;
        target_mem[upd_idx] <= bp.upd_target;
      end
    end
  end

endmodule

`default_nettype wire

//--- predictor/return_stack.sv
`timescale 1ns/1ns
`default_nettype none

module return_stack (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic                           push,
  input  wire logic                           pop,
  input  wire logic [frontend_pkg::xlen-1:0] push_addr,
  output logic [frontend_pkg::xlen-1:0]       top_addr
);
  import frontend_pkg::*;

  logic [xlen-1:0]      stack_mem [ras_depth];
  logic [ras_ptr_w-1:0] top_q;
  logic [ras_ptr_w-1:0] push_ptr;

  assign push_ptr = top_q + 1'b1;
  assign top_addr = stack_mem[top_q];

  // the pointer wraps, so a push on a full stack replaces the oldest entry.
  always_ff @(posedge clk) begin
    if (!rst) begin
      top_q <= '0;
      for (int i = 0; i < ras_depth; i++) begin
        stack_mem[i] <= reset_pc;
      end
    end else if (push) begin
      top_q <= push_ptr;
      stack_mem[push_ptr] <= push_addr;
    end else if (pop) begin
      top_q <= top_q - 1'b1;
    end
  end

  // a call and a return are never predicted for the same fetch.
  a_push_pop_excl: assert property (@(posedge clk) disable iff (!rst) !(push && pop));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module frontend_tb -o frontend_sim -f build.f

./obj_dir/frontend_sim 2>&1 | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- src/fetch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_buffer (
  input  wire logic                           clk,
  input  wire logic                           rst,
  fetch_mem_if.buffer                         fm,
  output logic                                mem_req_valid,
  output logic [frontend_pkg::xlen-1:0]       mem_req_addr,
  input  wire logic                           mem_credit,
  input  wire logic                           mem_rsp_valid,
  input  wire logic [frontend_pkg::xlen-1:0] mem_rsp_data
);
  import frontend_pkg::*;

  localparam int ptr_w = $clog2(buf_depth);

  logic [15:0]          hw_data [buf_depth];
  logic [xlen-1:0]      hw_addr [buf_depth];
  logic [ptr_w-1:0]     rd_ptr;
  logic [ptr_w-1:0]     wr_ptr;
  logic [ptr_w-1:0]     rd_next;
  logic [ptr_w-1:0]     wr_next;
  logic [buf_cnt_w-1:0] count_q;
  logic [credit_w-1:0]  credit_q;
  logic [credit_w-1:0]  inflight_q;
  logic [credit_w-1:0]  drop_q;
  logic [xlen-1:0]      req_addr_q;
  logic [xlen-1:0]      rsp_addr_q;
  logic                 skip_low_q;
  logic                 head_long;
  logic                 rsp_keep;
  logic                 pop_fire;
  logic [1:0]           push_n;
  logic [1:0]           pop_n;

  assign rd_next = rd_ptr + 1'b1;
  assign wr_next = wr_ptr + 1'b1;

  // ----------------------------------------------------------------------
  // parcel side
  // ----------------------------------------------------------------------

  assign head_long = (hw_data[rd_ptr][1:0] == 2'b11);
  assign fm.ready  = !fm.fence && (count_q != '0) && (hw_addr[rd_ptr] == fm.addr) &&
                     (!head_long || (count_q >= buf_cnt_w'(2)));
  assign fm.rdata  = {hw_data[rd_next], hw_data[rd_ptr]};
  assign pop_fire  = fm.valid && fm.ready;
  assign pop_n     = !pop_fire ? 2'd0 : (head_long ? 2'd2 : 2'd1);

  // ----------------------------------------------------------------------
  // memory side
  // ----------------------------------------------------------------------

  // room is held back for both halves of every response still on its way.
  assign mem_req_valid = !fm.fence && (credit_q != '0) &&
                         (int'(count_q) + 2 * (int'(inflight_q) + 1) <= buf_depth);
  assign mem_req_addr  = req_addr_q;

  assign rsp_keep = mem_rsp_valid && (drop_q == '0) && !fm.fence;
  assign push_n   = !rsp_keep ? 2'd0 : (skip_low_q ? 2'd1 : 2'd2);

  always_ff @(posedge clk) begin
    if (!rst) begin
      credit_q   <= credit_w'(mem_credits);
      inflight_q <= '0;
      drop_q     <= '0;
      count_q    <= '0;
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      skip_low_q <= 1'b0;
    end else begin
      credit_q   <= credit_q - credit_w'(mem_req_valid) + credit_w'(mem_credit);
      inflight_q <= inflight_q + credit_w'(mem_req_valid) - credit_w'(mem_rsp_valid);
      if (fm.fence) begin
        // whatever is still out belongs to the old path.
        drop_q     <= inflight_q - credit_w'(mem_rsp_valid);
        count_q    <= '0;
        rd_ptr     <= '0;
        wr_ptr     <= '0;
        skip_low_q <= fm.addr[1];
      end else begin
        if (mem_rsp_valid && (drop_q != '0)) begin
          drop_q <= drop_q - 1'b1;
        end
        count_q <= count_q + buf_cnt_w'(push_n) - buf_cnt_w'(pop_n);
        rd_ptr  <= rd_ptr + ptr_w'(pop_n);
        wr_ptr  <= wr_ptr + ptr_w'(push_n);
        if (rsp_keep) begin
          skip_low_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fm.fence) begin
      req_addr_q <= {fm.addr[xlen-1:2], 2'b00};
      rsp_addr_q <= {fm.addr[xlen-1:2], 2'b00};
    end else begin
      if (mem_req_valid) begin
        req_addr_q <= req_addr_q + xlen'(4);
      end
      if (rsp_keep) begin
        rsp_addr_q <= rsp_addr_q + xlen'(4);
        if (skip_low_q) begin
          hw_data[wr_ptr] <= mem_rsp_data[31:16];
          hw_addr[wr_ptr] <= rsp_addr_q + xlen'(2);
        end else begin
          hw_data[wr_ptr]  <= mem_rsp_data[15:0];
          hw_addr[wr_ptr]  <= rsp_addr_q;
          hw_data[wr_next] <= mem_rsp_data[31:16];
          hw_addr[wr_next] <= rsp_addr_q + xlen'(2);
        end
      end
    end
  end

  a_credit_limit: assert property (@(posedge clk) disable iff (!rst)
    credit_q <= credit_w'(mem_credits));

  a_queue_limit: assert property (@(posedge clk) disable iff (!rst)
    count_q <= buf_cnt_w'(buf_depth));

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic                           trap_valid,
  input  wire logic [frontend_pkg::xlen-1:0] trap_target,
  input  wire logic                           mret_valid,
  input  wire logic [frontend_pkg::xlen-1:0] mret_target,
  input  wire logic                           resolve_valid,
  input  wire logic [frontend_pkg::xlen-1:0] resolve_pc,
  input  wire frontend_pkg::cf_kind_t         resolve_kind,
  input  wire logic                           resolve_taken,
  input  wire logic [frontend_pkg::xlen-1:0] resolve_target,
  input  wire logic                           resolve_pred_taken,
  input  wire logic [frontend_pkg::xlen-1:0] resolve_pred_target,
  input  wire logic                           stall,
  fetch_mem_if.fetch                          mem,
  predict_if.fetch                            pred,
  output frontend_pkg::fetch_rec_t            rec
);
  import frontend_pkg::*;

  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] seq_pc;
  logic [xlen-1:0] resolve_seq;
  logic [xlen-1:0] instr;
  logic            fence_q;
  logic            ptk_long_q;
  logic            accept;
  logic            is_long;
  logic            mispredict;
  logic            redirect;
  logic            pred_jump;

  assign accept  = mem.valid && mem.ready;
  assign is_long = (mem.rdata[1:0] == 2'b11);
  assign instr   = is_long ? mem.rdata : {16'h0000, mem.rdata[15:0]};
  assign seq_pc  = pc_q + (is_long ? xlen'(4) : xlen'(2));

  // a not-taken surprise falls through past the last predicted-taken
  // instruction, whose length was kept when it was fetched.
  assign resolve_seq = resolve_pc + (ptk_long_q ? xlen'(4) : xlen'(2));
  assign mispredict  = resolve_valid && ((resolve_taken != resolve_pred_taken) ||
                       (resolve_taken && (resolve_target != resolve_pred_target)));
  assign redirect    = trap_valid || mret_valid || mispredict;
  assign pred_jump   = accept && pred.pred_hit && pred.pred_taken;

  // ----------------------------------------------------------------------
  // buffer and predictor side
  // ----------------------------------------------------------------------

  assign mem.valid = !stall && !fence_q;
  assign mem.fence = fence_q;
  assign mem.addr  = pc_q;

  assign pred.get_pc     = pc_q;
  assign pred.stall      = !accept || redirect;
  assign pred.upd_valid  = resolve_valid;
  assign pred.upd_pc     = resolve_pc;
  assign pred.upd_kind   = resolve_kind;
  assign pred.upd_taken  = resolve_taken;
  assign pred.upd_target = resolve_target;

  // ----------------------------------------------------------------------
  // next pc
  // ----------------------------------------------------------------------

  always_comb begin
    next_pc = pc_q;
    if (trap_valid) begin
      next_pc = trap_target;
    end else if (mret_valid) begin
      next_pc = mret_target;
    end else if (mispredict) begin
      next_pc = resolve_taken ? resolve_target : resolve_seq;
    end else if (pred_jump) begin
      // for a return the predictor hands over the top of its stack.
      next_pc = pred.pred_target;
    end else if (accept) begin
      next_pc = seq_pc;
    end
  end

  // fence starts set so the buffer is loaded with reset_pc on the way out of reset.
  always_ff @(posedge clk) begin
    if (!rst) begin
      pc_q       <= reset_pc;
      fence_q    <= 1'b1;
      ptk_long_q <= 1'b1;
      rec        <= '{pc: reset_pc, instr: nop_instr, taken: 1'b0, valid: 1'b0};
    end else begin
      pc_q <= next_pc;
      // every change of flow restarts the buffer at the new pc.
      fence_q <= redirect || pred_jump;
      if (pred_jump && !redirect) begin
        ptk_long_q <= is_long;
      end
      if (redirect) begin
        rec <= '{pc: next_pc, instr: nop_instr, taken: 1'b0, valid: 1'b0};
      end else if (accept) begin
        rec <= '{pc: pc_q, instr: instr, taken: pred_jump, valid: 1'b1};
      end else if (!stall) begin
        rec <= '{pc: pc_q, instr: nop_instr, taken: 1'b0, valid: 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

//--- src/frontend_top.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_top (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic                           trap_valid,
  input  wire logic [frontend_pkg::xlen-1:0] trap_target,
  input  wire logic                           mret_valid,
  input  wire logic [frontend_pkg::xlen-1:0] mret_target,
  input  wire logic                           resolve_valid,
  input  wire logic [frontend_pkg::xlen-1:0] resolve_pc,
  input  wire frontend_pkg::cf_kind_t         resolve_kind,
  input  wire logic                           resolve_taken,
  input  wire logic [frontend_pkg::xlen-1:0] resolve_target,
  input  wire logic                           resolve_pred_taken,
  input  wire logic [frontend_pkg::xlen-1:0] resolve_pred_target,
  input  wire logic                           stall,
  output logic                                fetch_valid,
  output logic [frontend_pkg::xlen-1:0]       fetch_pc,
  output logic [frontend_pkg::xlen-1:0]       fetch_instr,
  output logic                                fetch_taken,
  output logic                                mem_req_valid,
  output logic [frontend_pkg::xlen-1:0]       mem_req_addr,
  input  wire logic                           mem_credit,
  input  wire logic                           mem_rsp_valid,
  input  wire logic [frontend_pkg::xlen-1:0] mem_rsp_data
);
  import frontend_pkg::*;

  fetch_rec_t rec;

  fetch_mem_if fm_if ();
  predict_if   pr_if ();

  fetch_stage i_fetch (
    .clk                 (clk),
    .rst                 (rst),
    .trap_valid          (trap_valid),
    .trap_target         (trap_target),
    .mret_valid          (mret_valid),
    .mret_target         (mret_target),
    .resolve_valid       (resolve_valid),
    .resolve_pc          (resolve_pc),
    .resolve_kind        (resolve_kind),
    .resolve_taken       (resolve_taken),
    .resolve_target      (resolve_target),
    .resolve_pred_taken  (resolve_pred_taken),
    .resolve_pred_target (resolve_pred_target),
    .stall               (stall),
    .mem                 (fm_if),
    .pred                (pr_if),
    .rec                 (rec)
  );

  fetch_buffer i_buffer (
    .clk           (clk),
    .rst           (rst),
    .fm            (fm_if),
    .mem_req_valid (mem_req_valid),
    .mem_req_addr  (mem_req_addr),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data)
  );

  branch_predictor i_bp (
    .clk (clk),
    .rst (rst),
    .bp  (pr_if)
  );

  assign fetch_valid = rec.valid;
  assign fetch_pc    = rec.pc;
  assign fetch_instr = rec.instr;
  assign fetch_taken = rec.taken;

endmodule

`default_nettype wire

//--- testbench/frontend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_tb;
  import frontend_pkg::*;

  // about a hundred fetches at up to five cycles each, plus refills.
  localparam int cycle_limit = 3000;
  localparam logic [31:0] rand_seed = 32'h95f5b2c0;

  localparam logic [xlen-1:0] trap_vec = 32'h0000_0800;

  logic            clk;
  logic            rst;
  logic            trap_valid;
  logic [xlen-1:0] trap_target;
  logic            mret_valid;
  logic [xlen-1:0] mret_target;
  logic            resolve_valid;
  logic [xlen-1:0] resolve_pc;
  cf_kind_t        resolve_kind;
  logic            resolve_taken;
  logic [xlen-1:0] resolve_target;
  logic            resolve_pred_taken;
  logic [xlen-1:0] resolve_pred_target;
  logic            stall;
  logic            fetch_valid;
  logic [xlen-1:0] fetch_pc;
  logic [xlen-1:0] fetch_instr;
  logic            fetch_taken;
  logic            mem_req_valid;
  logic [xlen-1:0] mem_req_addr;
  logic            mem_credit = 1'b0;
  logic            mem_rsp_valid = 1'b0;
  logic [xlen-1:0] mem_rsp_data = '0;

  int              n_errors = 0;
  int              n_checks = 0;
  logic [xlen-1:0] exp_pc;

  logic [xlen-1:0] pend_addr [$];
  int              pend_due [$];
  int              mem_cyc = 0;
  int              last_due = 0;
  int              dly_min = 1;
  int              reqs_sent = 0;
  int              credits_back = 0;
  int              peak_out = 0;

  tb_clock i_clock (
    .clk (clk),
    .rst (rst)
  );

  frontend_top i_dut (
    .clk                 (clk),
    .rst                 (rst),
    .trap_valid          (trap_valid),
    .trap_target         (trap_target),
    .mret_valid          (mret_valid),
    .mret_target         (mret_target),
    .resolve_valid       (resolve_valid),
    .resolve_pc          (resolve_pc),
    .resolve_kind        (resolve_kind),
    .resolve_taken       (resolve_taken),
    .resolve_target      (resolve_target),
    .resolve_pred_taken  (resolve_pred_taken),
    .resolve_pred_target (resolve_pred_target),
    .stall               (stall),
    .fetch_valid         (fetch_valid),
    .fetch_pc            (fetch_pc),
    .fetch_instr         (fetch_instr),
    .fetch_taken         (fetch_taken),
    .mem_req_valid       (mem_req_valid),
    .mem_req_addr        (mem_req_addr),
    .mem_credit          (mem_credit),
    .mem_rsp_valid       (mem_rsp_valid),
    .mem_rsp_data        (mem_rsp_data)
  );

  // ----------------------------------------------------------------------
  // memory contents and expected instructions
  // ----------------------------------------------------------------------

  // halfwords in a set bit 3 region open a 32-bit instruction.
  function automatic logic [15:0] half_at(input logic [xlen-1:0] a);
    return {a[15:2], (a[3] ? 2'b11 : 2'b01)};
  endfunction

  function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] a);
    logic [xlen-1:0] base;
    base = {a[xlen-1:2], 2'b00};
    return {half_at(base + 32'd2), half_at(base)};
  endfunction

  function automatic int instr_len(input logic [xlen-1:0] pc);
    logic [15:0] low;
    low = half_at(pc);
    return (low[1:0] == 2'b11) ? 4 : 2;
  endfunction

  function automatic logic [xlen-1:0] instr_at(input logic [xlen-1:0] pc);
    if (instr_len(pc) == 4) begin
      return {half_at(pc + 32'd2), half_at(pc)};
    end
    return {16'h0000, half_at(pc)};
  endfunction

  function automatic fetch_rec_t current_rec();
    return '{pc: fetch_pc, instr: fetch_instr, taken: fetch_taken, valid: fetch_valid};
  endfunction

  // in-order responses, each after one to four cycles, with a credit back.
  always @(negedge clk) begin : memory_model
    int due;
    int outstanding;
    mem_cyc++;
    mem_rsp_valid = 1'b0;
    mem_credit    = 1'b0;
    if (rst === 1'b1) begin
      if ((pend_due.size() > 0) && (pend_due[0] <= mem_cyc)) begin
        mem_rsp_valid = 1'b1;
        mem_credit    = 1'b1;
        mem_rsp_data  = word_at(pend_addr.pop_front());
        due           = pend_due.pop_front();
        credits_back++;
      end
      if (mem_req_valid === 1'b1) begin
        check_count("mem_req_addr bits 1:0", int'(mem_req_addr[1:0]), 0);
        due = mem_cyc + dly_min + int'($urandom % 32'(5 - dly_min));
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_addr.push_back(mem_req_addr);
        pend_due.push_back(due);
        reqs_sent++;
      end
      outstanding = reqs_sent - credits_back;
      if (outstanding > peak_out) begin
        peak_out = outstanding;
      end
      if (outstanding > mem_credits) begin
        n_errors++;
        $display("error at %0t ns: %0d memory requests are outstanding with %0d credits",
                 $time, outstanding, mem_credits);
      end
    end
  end

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------

  task automatic check_pc(input string what, input logic [xlen-1:0] got,
                          input logic [xlen-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_instr(input string what, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_rec(input string what, input fetch_rec_t got, input fetch_rec_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH at %0t ns: %s is pc %08h instr %08h taken %0b valid %0b",
               $time, what, got.pc, got.instr, got.taken, got.valid);
      $display("  expected pc %08h instr %08h taken %0b valid %0b",
               exp.pc, exp.instr, exp.taken, exp.valid);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH at %0t ns: %s is %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------

  // redirect and resolve inputs last for exactly one cycle.
  task automatic next_cycle();
    @(negedge clk);
    trap_valid    = 1'b0;
    mret_valid    = 1'b0;
    resolve_valid = 1'b0;
  endtask

  task automatic next_fetch_is(input logic taken, input logic [xlen-1:0] target);
    do begin
      next_cycle();
    end while (fetch_valid !== 1'b1);
    check_pc("fetch_pc", fetch_pc, exp_pc);
    check_instr("fetch_instr", fetch_instr, instr_at(exp_pc));
    check_flag("fetch_taken", fetch_taken, taken);
    if (taken) begin
      exp_pc = target;
    end else begin
      exp_pc = exp_pc + xlen'(instr_len(exp_pc));
    end
  endtask

  task automatic follow_stream(input int n);
    repeat (n) next_fetch_is(1'b0, '0);
  endtask

  task automatic raise_trap(input logic [xlen-1:0] target);
    trap_valid  = 1'b1;
    trap_target = target;
    exp_pc      = target;
  endtask

  task automatic return_from_trap(input logic [xlen-1:0] target);
    mret_valid  = 1'b1;
    mret_target = target;
    exp_pc      = target;
  endtask

  task automatic resolve_transfer(input logic [xlen-1:0] pc, input cf_kind_t kind,
                                  input logic taken, input logic [xlen-1:0] target,
                                  input logic pred_taken, input logic [xlen-1:0] pred_target);
    resolve_valid       = 1'b1;
    resolve_pc          = pc;
    resolve_kind        = kind;
    resolve_taken       = taken;
    resolve_target      = target;
    resolve_pred_taken  = pred_taken;
    resolve_pred_target = pred_target;
    if ((taken != pred_taken) || (taken && (target != pred_target))) begin
      exp_pc = taken ? target : pc + xlen'(instr_len(pc));
    end
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------

  task automatic sequential_from_reset();
    fetch_rec_t idle;
    idle = '{pc: reset_pc, instr: nop_instr, taken: 1'b0, valid: 1'b0};
    repeat (3) @(negedge clk);
    check_rec("record in reset", current_rec(), idle);
    check_flag("mem_req_valid in reset", mem_req_valid, 1'b0);
    wait (rst === 1'b1);
    exp_pc = reset_pc;
    follow_stream(20);
  endtask

  task automatic credit_limit_slow_memory();
    peak_out = 0;
    dly_min  = 4;
    follow_stream(16);
    check_count("peak outstanding requests", peak_out, mem_credits);
    dly_min = 1;
  endtask

  task automatic trap_then_mret();
    logic [xlen-1:0] resume_pc;
    follow_stream(3);
    resume_pc = exp_pc;
    raise_trap(trap_vec);
    follow_stream(5);
    return_from_trap(resume_pc);
    follow_stream(5);
  endtask

  task automatic branch_training();
    logic [xlen-1:0] br_pc;
    logic [xlen-1:0] br_target;
    br_pc     = 32'h0000_0404;
    br_target = 32'h0000_0480;
    raise_trap(32'h0000_0400);
    follow_stream(4);
    resolve_transfer(br_pc, branch, 1'b1, br_target, 1'b0, '0);
    follow_stream(3);
    resolve_transfer(br_pc, branch, 1'b1, br_target, 1'b1, br_target);
    follow_stream(2);
    resolve_transfer(br_pc, branch, 1'b1, br_target, 1'b1, br_target);
    follow_stream(2);
    raise_trap(32'h0000_0400);
    follow_stream(2);
    next_fetch_is(1'b1, br_target);
    follow_stream(3);
  endtask

  // the call is a 32-bit instruction, so its return lands at pc plus 4.
  task automatic call_return_training();
    logic [xlen-1:0] call_pc;
    logic [xlen-1:0] func_pc;
    logic [xlen-1:0] ret_pc;
    call_pc = 32'h0000_0608;
    func_pc = 32'h0000_0700;
    ret_pc  = 32'h0000_0704;
    raise_trap(32'h0000_0600);
    follow_stream(5);
    resolve_transfer(call_pc, jump_call, 1'b1, func_pc, 1'b0, '0);
    follow_stream(3);
    resolve_transfer(ret_pc, ret, 1'b1, call_pc + 32'd4, 1'b0, '0);
    follow_stream(2);
    raise_trap(32'h0000_0600);
    follow_stream(4);
    next_fetch_is(1'b1, func_pc);
    follow_stream(2);
    next_fetch_is(1'b1, call_pc + 32'd4);
    follow_stream(2);
  endtask

  task automatic stall_hold();
    fetch_rec_t held;
    follow_stream(3);
    held  = current_rec();
    stall = 1'b1;
    repeat (6) begin
      next_cycle();
      check_rec("record under stall", current_rec(), held);
    end
    stall = 1'b0;
    follow_stream(8);
  endtask

  // ----------------------------------------------------------------------
  // run control
  // ----------------------------------------------------------------------

  initial begin
    void'($urandom(rand_seed));
    trap_valid          = 1'b0;
    trap_target         = '0;
    mret_valid          = 1'b0;
    mret_target         = '0;
    resolve_valid       = 1'b0;
    resolve_pc          = '0;
    resolve_kind        = none;
    resolve_taken       = 1'b0;
    resolve_target      = '0;
    resolve_pred_taken  = 1'b0;
    resolve_pred_target = '0;
    stall               = 1'b0;
    exp_pc              = reset_pc;

    sequential_from_reset();
    credit_limit_slow_memory();
    trap_then_mret();
    branch_training();
    call_return_training();
    stall_hold();

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (cycle_limit) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int half_period = 2;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // reset is held low for five rising edges and let go on a falling edge.
  initial begin
    rst = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
  end

endmodule

`default_nettype wire
